/* vlog.f */
eclk_pkg.sv
lock_sync.sv
reset_sequencer.sv
clk_enable_gen.sv
host_ctrl_port.sv
eclocks_top.sv
eclocks_props.sv
tb_eclocks.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the eclocks testbench with Verilator, result taken from sim.log
rm -f sim.log build.log &&
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
   --top-module tb_eclocks > build.log 2>&1 &&
{ ./obj_dir/Vtb_eclocks > sim.log 2>&1 || true; } &&
grep -q "SIMULATION PASSED" sim.log &&
echo "run passed" ||
{ echo "run failed, see build.log and sim.log"; exit 1; }

/* tb_eclocks.sv */
// testbench for the link clock/reset sequencer, drives the host port and lock flags, props bound in
`timescale 1ns/1ps

module tb_eclocks;
   import eclk_pkg::*;

   localparam int SEED      = 21317;
   localparam int HB_CYCLES = 2 ** HB_WIDTH;
   localparam int SEQ_LIMIT = 7 * HB_CYCLES + 40;   // seven heartbeats plus slack
   localparam int HS_LIMIT  = 20;                   // bound on any handshake phase

   // decoded resets expected in the states that get checked
   localparam rst_out_t EXP_RST_ALL    = '{link_rst: 1'b1, chip_rstb: 1'b0, cclk_pll_rst: 1'b1,
                                           rx_pll_rst: 1'b1, idelay_rst: 1'b1};
   localparam rst_out_t EXP_START_CCLK = '{link_rst: 1'b1, chip_rstb: 1'b0, cclk_pll_rst: 1'b0,
                                           rx_pll_rst: 1'b1, idelay_rst: 1'b1};
   localparam rst_out_t EXP_ACTIVE     = '{link_rst: 1'b0, chip_rstb: 1'b1, cclk_pll_rst: 1'b0,
                                           rx_pll_rst: 1'b0, idelay_rst: 1'b0};

   logic      sys_clk;
   logic      reset_in;
   logic      req_i;
   host_req_t cmd_i;
   logic      ack_o;
   host_rsp_t rsp_o;
   lock_t     lock_i;
   rst_out_t  rst_o;
   logic      logic_stb_o;
   logic      tx90_stb_o;
   logic      cclk_o;
   logic      rst_pattern;         // link, chip and rx pll all held
   logic      prev_cclk;
   host_rsp_t last_rsp;            // status from the last handshake
   int        cycle_cnt = 0;
   int        last_live_cyc = 0;   // last edge without the reset pattern
   int        ack_cyc;             // edge where the last ack rise was seen
   int        err_cnt = 0;
   int        err_base = 0;
   int        test_cnt = 0;
   int        fail_cnt = 0;
   int        stall;
   int        stb_cnt;
   int        tx_cnt;
   int        tgl_cnt;

   eclocks_top u_eclocks_top (
      .sys_clk     (sys_clk),
      .reset_in    (reset_in),
      .req_i       (req_i),
      .cmd_i       (cmd_i),
      .ack_o       (ack_o),
      .rsp_o       (rsp_o),
      .lock_i      (lock_i),
      .rst_o       (rst_o),
      .logic_stb_o (logic_stb_o),
      .tx90_stb_o  (tx90_stb_o),
      .cclk_o      (cclk_o)
   );

   bind eclocks_top eclocks_props u_eclocks_props (
      .sys_clk     (sys_clk),
      .reset_in    (reset_in),
      .req_i       (req_i),
      .cmd_i       (cmd_i),
      .ack_o       (ack_o),
      .rst_o       (rst_o),
      .logic_stb_o (logic_stb_o),
      .tx90_stb_o  (tx90_stb_o),
      .cclk_o      (cclk_o)
   );

   assign rst_pattern = rst_o.link_rst && !rst_o.chip_rstb && rst_o.rx_pll_rst;

   initial
   begin
      sys_clk = 1'b0;
      forever #2 sys_clk = ~sys_clk;   // 4 ns period
   end

   // edge count and last edge seen out of the reset pattern
   always @(posedge sys_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (!rst_pattern)
         last_live_cyc <= cycle_cnt;
   end

   initial
   begin
      #20000;
      $display("watchdog expired, the run never reached its end");
      $display("SIMULATION FAILED");
      $finish;
   end

   //####################
   // helpers
   //####################
   task automatic expect_true(input logic cond, input string msg);
      assert (cond)
      else
      begin
         $display("error at %0t: %s", $time, msg);
         err_cnt++;
      end
   endtask

   task automatic report_timeout(input string msg);
      $display("timeout at %0t: %s", $time, msg);
      err_cnt++;
   endtask

   // own checks plus failed bound assertions
   function automatic int total_errors();
      return err_cnt + u_eclocks_top.u_eclocks_props.prop_err_cnt;
   endfunction

   // one four-phase transfer, called on a rising edge
   task automatic host_cmd(input host_op_e op);
      int n;
      req_i <= 1'b1;
      cmd_i <= '{op: op};
      n = 0;
      @(posedge sys_clk);
      while (!ack_o && n < HS_LIMIT)
      begin
         @(posedge sys_clk);
         n++;
      end
      if (!ack_o)
         report_timeout("no ack for the host request");
      ack_cyc  = cycle_cnt;
      last_rsp = rsp_o;       // valid while ack high
      req_i   <= 1'b0;
      n = 0;
      @(posedge sys_clk);
      while (ack_o && n < HS_LIMIT)
      begin
         @(posedge sys_clk);
         n++;
      end
      if (ack_o)
         report_timeout("ack stayed high after req dropped");
      cmd_i <= '{op: OP_NOP};
   endtask

   task automatic expect_status(input host_rsp_t exp);
      host_cmd(OP_STATUS);
      expect_true(last_rsp == exp, $sformatf("status %b, expected %b", last_rsp, exp));
   endtask

   task automatic wait_active;
      int n;
      n = 0;
      while (rst_o.rx_pll_rst && n < SEQ_LIMIT)
      begin
         @(posedge sys_clk);
         n++;
      end
      if (rst_o.rx_pll_rst)
         report_timeout("sequencer never reached ACTIVE");
   endtask

   // reset pattern must be back within 3 cycles of the ack rise
   task automatic expect_reset_by_ack;
      int n;
      n = 0;
      while (!rst_pattern && n < HS_LIMIT)
      begin
         @(posedge sys_clk);
         n++;
      end
      if (!rst_pattern)
         report_timeout("reset pattern never came back");
      expect_true(last_live_cyc <= ack_cyc + 2, "reset pattern later than 3 cycles after ack");
   endtask

   task automatic hold_in_reset(input int cycles, input string msg);
      repeat (cycles)
      begin
         @(posedge sys_clk);
         expect_true(rst_pattern, msg);
      end
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = total_errors();
      test_cnt++;
      if (errs == err_base)
         $display("test %0d %s: ok", test_cnt, name);
      else
      begin
         fail_cnt++;
         $display("test %0d %s: failed", test_cnt, name);
      end
      err_base = errs;
   endtask

   //####################
   // test sequence
   //####################
   initial
   begin
      void'($urandom(SEED));
      reset_in <= 1'b1;
      req_i    <= 1'b0;
      cmd_i    <= '{op: OP_NOP};
      lock_i   <= '0;
      repeat (10) @(posedge sys_clk);
      reset_in <= 1'b0;
      @(posedge sys_clk);
      expect_true(rst_o == EXP_RST_ALL && !ack_o && !logic_stb_o && !tx90_stb_o && !cclk_o,
         "outputs not quiet after reset");
      end_test("after reset");

      expect_status('{state: RST_ALL, cclk_lock: 1'b0, rx_lock: 1'b0, enable: 1'b0});
      end_test("handshake");

      lock_i <= '{cclk_lock: 1'b1, rx_lock: 1'b1};
      host_cmd(OP_ENABLE);
      wait_active;
      expect_true(rst_o == EXP_ACTIVE, "resets not all released in ACTIVE");
      expect_status('{state: ACTIVE, cclk_lock: 1'b1, rx_lock: 1'b1, enable: 1'b1});
      end_test("full sequence");

      host_cmd(OP_DISABLE);
      lock_i <= '{cclk_lock: 1'b0, rx_lock: 1'b1};   // chip clock pll loses lock
      host_cmd(OP_ENABLE);
      stall = 3 * HB_CYCLES + int'($urandom % HB_CYCLES);
      hold_in_reset(stall, "link reset dropped without chip clock lock");
      expect_true(rst_o == EXP_START_CCLK, "resets wrong while waiting for chip clock lock");
      expect_status('{state: START_CCLK, cclk_lock: 1'b0, rx_lock: 1'b1, enable: 1'b1});
      lock_i <= '{cclk_lock: 1'b1, rx_lock: 1'b1};
      wait_active;
      end_test("lock wait");

      host_cmd(OP_RESTART);
      expect_reset_by_ack;
      wait_active;               // enable still set, runs again
      host_cmd(OP_DISABLE);
      expect_reset_by_ack;
      hold_in_reset(HB_CYCLES + int'($urandom % HB_CYCLES), "sequence left reset while disabled");
      expect_status('{state: RST_ALL, cclk_lock: 1'b1, rx_lock: 1'b1, enable: 1'b0});
      end_test("disable and restart");

      host_cmd(OP_ENABLE);
      wait_active;
      stb_cnt   = 0;
      tx_cnt    = 0;
      tgl_cnt   = 0;
      prev_cclk = cclk_o;
      repeat (16 * DIV_RATIO)
      begin
         @(posedge sys_clk);
         if (logic_stb_o)
            stb_cnt++;
         if (tx90_stb_o)
            tx_cnt++;
         if (cclk_o != prev_cclk)
            tgl_cnt++;
         prev_cclk = cclk_o;
      end
      expect_true(stb_cnt == 16 && tx_cnt == 16, "strobe count wrong over 64 cycles");
      expect_true(tgl_cnt == 16 * DIV_RATIO, "chip clock missed toggles");
      end_test("strobes");

      $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, total_errors());
      if (total_errors() == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* eclocks_props.sv */
// concurrent checks on handshake, reset order and strobes, bound into the sequencer top level
`timescale 1ns/1ps

module eclocks_props (
   input logic                sys_clk,
   input logic                reset_in,
   input logic                req_i,
   input eclk_pkg::host_req_t cmd_i,
   input logic                ack_o,
   input eclk_pkg::rst_out_t  rst_o,
   input logic                logic_stb_o,
   input logic                tx90_stb_o,
   input logic                cclk_o
);
   import eclk_pkg::*;

   logic rst_pattern;       // link, chip and rx pll all held
   int   prop_err_cnt = 0;  // assertion failures so far

   assign rst_pattern = rst_o.link_rst && !rst_o.chip_rstb && rst_o.rx_pll_rst;

   task automatic count_failure(input string msg);
      prop_err_cnt++;
      $error("%s", msg);
   endtask

   //####################
   // handshake
   //####################
   a_ack_rise : assert property (@(posedge sys_clk) disable iff (reset_in)
      (req_i && !ack_o) |=> ack_o) else count_failure("ack did not rise one cycle after req");
   a_ack_fall : assert property (@(posedge sys_clk) disable iff (reset_in)
      (!req_i && ack_o) |=> !ack_o) else count_failure("ack did not fall one cycle after req");
   a_ack_src : assert property (@(posedge sys_clk) disable iff (reset_in)
      $rose(ack_o) |-> $past(req_i)) else count_failure("ack rose without a request");
   a_cmd_rst : assert property (@(posedge sys_clk) disable iff (reset_in)
      ($rose(ack_o) && (cmd_i.op inside {OP_DISABLE, OP_RESTART})) |-> ##3 rst_pattern)
      else count_failure("reset pattern late after disable or restart");

   // chip leaves reset before the link does
   a_chip_first : assert property (@(posedge sys_clk) disable iff (reset_in)
      $fell(rst_o.link_rst) |-> $past(rst_o.chip_rstb))
      else count_failure("link out of reset before chip");

   //####################
   // strobes and chip clock
   //####################
   a_stb_period : assert property (@(posedge sys_clk) disable iff (reset_in)
      logic_stb_o |=> !logic_stb_o ##1 !logic_stb_o ##1 !logic_stb_o
      ##1 (logic_stb_o || rst_o.link_rst)) else count_failure("logic strobe not every 4 cycles");
   a_tx90 : assert property (@(posedge sys_clk) disable iff (reset_in)
      logic_stb_o |=> (tx90_stb_o || rst_o.link_rst)) else count_failure("tx90 strobe missing");
   a_stb_quiet : assert property (@(posedge sys_clk) disable iff (reset_in)
      rst_o.link_rst |-> (!logic_stb_o && !tx90_stb_o))
      else count_failure("strobe during link reset");
   a_cclk_off : assert property (@(posedge sys_clk) disable iff (reset_in)
      rst_o.cclk_pll_rst |-> !cclk_o) else count_failure("chip clock high while its pll is reset");
   a_cclk_tgl : assert property (@(posedge sys_clk) disable iff (reset_in)
      (!rst_o.cclk_pll_rst && $past(!rst_o.cclk_pll_rst)) |-> (cclk_o != $past(cclk_o)))
      else count_failure("chip clock missed a toggle");

endmodule

/* eclocks_top.sv */
// top of the link clock/reset sequencer, wires host port, lock sync, sequencer and enables together
`timescale 1ns/1ps

module eclocks_top (
   input  logic                sys_clk,
   input  logic                reset_in,
   // host side
   input  logic                req_i,
   input  eclk_pkg::host_req_t cmd_i,
   output logic                ack_o,
   output eclk_pkg::host_rsp_t rsp_o,
   // pll lock flags, raw
   input  eclk_pkg::lock_t     lock_i,
   // resets and clock enables
   output eclk_pkg::rst_out_t  rst_o,
   output logic                logic_stb_o,
   output logic                tx90_stb_o,
   output logic                cclk_o
);
   import eclk_pkg::*;

   logic       link_en;     // port to sequencer
   logic       restart;     // port to sequencer, pulse
   rst_state_e state;       // sequencer to port
   lock_t      lock_s;      // synchronized locks
   logic       cclk_run;
   logic       logic_run;

   //####################
   // host command port
   //####################
   host_ctrl_port u_host_ctrl_port (
      .sys_clk   (sys_clk),
      .reset_in  (reset_in),
      .req_i     (req_i),
      .cmd_i     (cmd_i),
      .state_i   (state),
      .lock_i    (lock_s),
      .ack_o     (ack_o),
      .rsp_o     (rsp_o),
      .link_en_o (link_en),
      .restart_o (restart)
   );

   lock_sync u_lock_sync (
      .sys_clk  (sys_clk),
      .reset_in (reset_in),
      .lock_i   (lock_i),
      .lock_o   (lock_s)
   );

   //####################
   // sequence and enables
   //####################
   reset_sequencer u_reset_sequencer (
      .sys_clk     (sys_clk),
      .reset_in    (reset_in),
      .link_en_i   (link_en),
      .restart_i   (restart),
      .lock_i      (lock_s),
      .state_o     (state),
      .rst_o       (rst_o),
      .cclk_run_o  (cclk_run),
      .logic_run_o (logic_run)
   );

   clk_enable_gen u_clk_enable_gen (
      .sys_clk     (sys_clk),
      .reset_in    (reset_in),
      .cclk_run_i  (cclk_run),
      .logic_run_i (logic_run),
      .logic_stb_o (logic_stb_o),
      .tx90_stb_o  (tx90_stb_o),
      .cclk_o      (cclk_o)
   );

endmodule

/* host_ctrl_port.sv */
// host command port with four-phase req/ack, holds link enable, issues restart, returns status
`timescale 1ns/1ps

module host_ctrl_port (
   input  logic                 sys_clk,
   input  logic                 reset_in,
   input  logic                 req_i,
   input  eclk_pkg::host_req_t  cmd_i,      // stable while req_i high
   input  eclk_pkg::rst_state_e state_i,    // from sequencer
   input  eclk_pkg::lock_t      lock_i,     // synchronized locks
   output logic                 ack_o,
   output eclk_pkg::host_rsp_t  rsp_o,      // valid while ack_o high
   output logic                 link_en_o,
   output logic                 restart_o   // one cycle
);
   import eclk_pkg::*;

   typedef enum logic [1:0] {
      HS_IDLE,       // waiting for req
      HS_ACK,        // first ack cycle, command executed
      HS_WAIT_REL    // ack held until req drops
   } hs_state_e;

   hs_state_e hs_state_q;
   logic      accept;      // new request taken this cycle
   logic      link_en_q;
   logic      en_next;     // enable after this command
   logic      restart_q;
   host_rsp_t rsp_q;

   assign accept = (hs_state_q == HS_IDLE) && req_i;

   // enable update per opcode
   always_comb
   begin
      en_next = link_en_q;
      case (cmd_i.op)
         OP_ENABLE:  en_next = 1'b1;
         OP_DISABLE: en_next = 1'b0;
         default:    en_next = link_en_q;   // nop, restart, status
      endcase
   end

   //####################
   // handshake FSM
   //####################
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         hs_state_q <= HS_IDLE;
         link_en_q  <= 1'b0;   // link held off until enabled
         restart_q  <= 1'b0;
      end
      else
      begin
         restart_q <= accept && (cmd_i.op == OP_RESTART);   // lines up with ack rise
         if (accept)
         begin
            link_en_q <= en_next;
         end
         case (hs_state_q)
            HS_IDLE:     if (req_i)  hs_state_q <= HS_ACK;
            HS_ACK:      hs_state_q <= req_i ? HS_WAIT_REL : HS_IDLE;
            HS_WAIT_REL: if (!req_i) hs_state_q <= HS_IDLE;
            default:     hs_state_q <= HS_IDLE;
         endcase
      end
   end

   // status snapshot taken at accept
   always_ff @(posedge sys_clk)
   begin
      if (accept)
      begin
         rsp_q.state     <= state_i;
         rsp_q.cclk_lock <= lock_i.cclk_lock;
         rsp_q.rx_lock   <= lock_i.rx_lock;
         rsp_q.enable    <= en_next;
      end
   end

   assign ack_o     = (hs_state_q != HS_IDLE);
   assign rsp_o     = rsp_q;
   assign link_en_o = link_en_q;
   assign restart_o = restart_q;

endmodule

/* clk_enable_gen.sv */
// sys_clk enable generator standing in for the link plls, divide strobes and a gated chip clock
`timescale 1ns/1ps

module clk_enable_gen (
   input  logic sys_clk,
   input  logic reset_in,
   input  logic cclk_run_i,    // from sequencer
   input  logic logic_run_i,   // from sequencer
   output logic logic_stb_o,   // slow logic enable, phase 0
   output logic tx90_stb_o,    // quarter period later, phase 1
   output logic cclk_o         // chip clock, half sys_clk rate
);
   import eclk_pkg::*;

   logic [PH_WIDTH-1:0] phase_q;  // strobe phase
   logic                cclk_q;   // toggle flop

   //####################
   // strobe phase
   //####################
   always_ff @(posedge sys_clk)
   begin
      if (reset_in || !logic_run_i)
      begin
         phase_q <= '0;   // restart at phase 0 on every release
      end
      else if (phase_q == PH_WIDTH'(DIV_RATIO - 1))
      begin
         phase_q <= '0;
      end
      else
      begin
         phase_q <= phase_q + 1'b1;
      end
   end

   assign logic_stb_o = logic_run_i && (phase_q == PH_WIDTH'(0));
   assign tx90_stb_o  = logic_run_i && (phase_q == PH_WIDTH'(1));  // 90 degrees of DIV_RATIO

   //####################
   // chip clock
   //####################
   always_ff @(posedge sys_clk)
   begin
      if (reset_in || !cclk_run_i)
      begin
         cclk_q <= 1'b0;
      end
      else
      begin
         cclk_q <= ~cclk_q;
      end
   end

   // masked so the clock drops on the same edge the pll reset rises
   assign cclk_o = cclk_q & cclk_run_i;

endmodule

/* reset_sequencer.sv */
// reset sequence FSM paced by a heartbeat, drives link/chip/pll/idelay resets and clock run enables
`timescale 1ns/1ps

module reset_sequencer (
   input  logic                 sys_clk,
   input  logic                 reset_in,
   input  logic                 link_en_i,    // level from host port
   input  logic                 restart_i,    // one cycle pulse from host port
   input  eclk_pkg::lock_t      lock_i,       // already synchronized
   output eclk_pkg::rst_state_e state_o,
   output eclk_pkg::rst_out_t   rst_o,
   output logic                 cclk_run_o,   // chip clock may toggle
   output logic                 logic_run_o   // logic strobes may run
);
   import eclk_pkg::*;

   logic [HB_WIDTH-1:0] hb_cnt_q;   // free running
   logic                hb_q;       // one cycle heartbeat
   logic                rst_ctl_q;  // registered restart condition
   rst_state_e          state_q;
   rst_out_t            rst_d;

   //####################
   // heartbeat
   //####################
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         hb_cnt_q <= '0;
         hb_q     <= 1'b0;
      end
      else
      begin
         hb_cnt_q <= hb_cnt_q + 1'b1;   // wraps
         hb_q     <= &hb_cnt_q;         // high one cycle after the all-ones count
      end
   end

   // reset request, any source, registered once
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         rst_ctl_q <= 1'b1;
      end
      else
      begin
         rst_ctl_q <= ~link_en_i | restart_i;
      end
   end

   //####################
   // sequence FSM
   //####################
   // at most one step per heartbeat, two lock checkpoints on the chip clock pll
   always_ff @(posedge sys_clk)
   begin
      if (reset_in || rst_ctl_q)
      begin
         state_q <= RST_ALL;
      end
      else if (hb_q)
      begin
         case (state_q)
            RST_ALL:
            begin
               state_q <= START_CCLK;
            end
            START_CCLK:
            begin
               if (lock_i.cclk_lock)
               begin
                  state_q <= STOP_CCLK;   // pll settled
               end
            end
            STOP_CCLK:
            begin
               state_q <= START_CHIP;
            end
            START_CHIP:
            begin
               state_q <= HOLD;
            end
            HOLD:
            begin
               if (lock_i.cclk_lock)
               begin
                  state_q <= TX_ACTIVE;   // relocked after restart of clock
               end
            end
            TX_ACTIVE:
            begin
               state_q <= ACTIVE;
            end
            ACTIVE:
            begin
               state_q <= ACTIVE;   // parked until next reset
            end
            default:
            begin
               state_q <= RST_ALL;  // unused encoding
            end
         endcase
      end
   end

   //####################
   // decoded resets
   //####################
   always_comb
   begin
      rst_d.link_rst     = !(state_q inside {TX_ACTIVE, ACTIVE});
      rst_d.chip_rstb    = state_q inside {START_CHIP, HOLD, TX_ACTIVE, ACTIVE};
      rst_d.cclk_pll_rst = state_q inside {RST_ALL, STOP_CCLK, START_CHIP};  // quiet around chip edge
      rst_d.rx_pll_rst   = (state_q != ACTIVE);
      rst_d.idelay_rst   = state_q inside {RST_ALL, START_CCLK};
   end

   assign state_o     = state_q;
   assign rst_o       = rst_d;
   assign cclk_run_o  = ~rst_d.cclk_pll_rst;  // clock runs whenever its pll is out of reset
   assign logic_run_o = ~rst_d.link_rst;

endmodule

/* lock_sync.sv */
// brings the two pll lock flags into sys_clk, one independent flop chain per flag
`timescale 1ns/1ps

module lock_sync (
   input  logic            sys_clk,
   input  logic            reset_in,
   input  eclk_pkg::lock_t lock_i,   // raw, async to sys_clk
   output eclk_pkg::lock_t lock_o    // synchronized
);
   import eclk_pkg::*;

   logic [1:0]                  lock_raw;  // flattened flags, bit 1 is cclk
   logic [1:0][SYNC_STAGES-1:0] sync_q;    // one chain per flag

   assign lock_raw = lock_i;

   // per-bit chains, no sharing between the two flags
   for (genvar i = 0; i < 2; i++)
   begin : g_chain
      always_ff @(posedge sys_clk)
      begin
         if (reset_in)
         begin
            sync_q[i] <= '0;   // report unlocked out of reset
         end
         else
         begin
            sync_q[i] <= {sync_q[i][SYNC_STAGES-2:0], lock_raw[i]};  // shift in at bit 0
         end
      end
   end

   // last stage of each chain
   assign lock_o.cclk_lock = sync_q[1][SYNC_STAGES-1];
   assign lock_o.rx_lock   = sync_q[0][SYNC_STAGES-1];

endmodule

/* eclk_pkg.sv */
// shared types and timing constants for the link clock/reset sequencer, imported by every block
package eclk_pkg;

   //####################
   // timing
   //####################
   localparam int HB_WIDTH    = 4;                  // heartbeat every 2**HB_WIDTH cycles
   localparam int SYNC_STAGES = 2;                  // lock synchronizer depth
   localparam int DIV_RATIO   = 4;                  // logic strobe divide
   localparam int PH_WIDTH    = $clog2(DIV_RATIO);  // strobe phase counter width

   //####################
   // sequencer states
   //####################
   typedef enum logic [2:0] {
      RST_ALL    = 3'd0,   // everything held
      START_CCLK = 3'd1,   // chip clock pll released, wait for lock
      STOP_CCLK  = 3'd2,   // quiet time before chip reset edge
      START_CHIP = 3'd3,   // chip reset released
      HOLD       = 3'd4,   // clock back on, wait for lock again
      TX_ACTIVE  = 3'd5,   // link logic out of reset
      ACTIVE     = 3'd6    // rx pll released, parked here
   } rst_state_e;

   // host command opcodes
   typedef enum logic [2:0] {
      OP_NOP     = 3'd0,
      OP_ENABLE  = 3'd1,
      OP_DISABLE = 3'd2,
      OP_RESTART = 3'd3,
      OP_STATUS  = 3'd4
   } host_op_e;

   //####################
   // bundles
   //####################
   typedef struct packed {
      host_op_e op;
   } host_req_t;

   typedef struct packed {
      rst_state_e state;      // sequencer state at accept
      logic       cclk_lock;  // synchronized
      logic       rx_lock;    // synchronized
      logic       enable;     // link enable after the command
   } host_rsp_t;

   typedef struct packed {
      logic cclk_lock;
      logic rx_lock;
   } lock_t;

   typedef struct packed {
      logic link_rst;      // link logic and io
      logic chip_rstb;     // attached chip, active low
      logic cclk_pll_rst;
      logic rx_pll_rst;
      logic idelay_rst;
   } rst_out_t;

endpackage
